//--- verilog.f
common/axi_pkg.sv
common/mem_pkg.sv
hdl/read_arbiter.sv
wbuffer/wbuffer_store.sv
wbuffer/wbuffer_drain.sv
hdl/mem_subsys_top.sv
test/wbuffer_drain_chk.sv
test/tb_mem_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_mem_subsys -o sim_tb_mem_subsys \
    && ./obj_dir/sim_tb_mem_subsys | tee /dev/stderr | grep -qx "=== PASS ===" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/tb_mem_subsys.sv
module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_WRITES = 300;
    localparam int N_READS  = 300;
    localparam int LIMIT    = 300 * 2 * (9 * 4 + 12);
    localparam logic [31:0] INIT_XOR = 32'h5A5A_C3C3;

    logic aclk;
    logic reset_i;
    mem_pkg::rd_req_t     ar_req [2];
    logic                 ar_valid [2];
    logic                 r_ready [2];
    logic                 fetch_ar_ready_o, data_ar_ready_o;
    mem_pkg::rd_beat_t    fetch_r_o, data_r_o;
    logic                 fetch_r_valid_o, data_r_valid_o;
    mem_pkg::wbuf_entry_t wb_req_i;
    logic                 wb_req_valid_i, wb_req_ready_o, wb_empty_o;
    mem_pkg::paddr_t      lookup_paddr_i;
    logic                 lookup_hit_o;
    mem_pkg::line_t       lookup_line_o;
    axi_pkg::axi_ar_t     m_ar_o;
    logic                 m_ar_valid_o, m_ar_ready_i;
    axi_pkg::axi_r_t      m_r_i;
    logic                 m_r_valid_i, m_r_ready_o;
    axi_pkg::axi_aw_t     m_aw_o;
    logic                 m_aw_valid_o, m_aw_ready_i;
    axi_pkg::axi_w_t      m_w_o;
    logic                 m_w_valid_o, m_w_ready_i, m_b_valid_i, m_b_ready_o;

    logic [31:0] rng_q;
    mem_pkg::wbuf_entry_t wq [$];        // pending write entries, oldest first
    axi_pkg::axi_ar_t     slv_q [$];     // reads accepted by the slave model
    mem_pkg::word_t       wr_mem [mem_pkg::paddr_t];
    int unsigned slv_beat, w_beat, writes_sent, writes_done, reads_issued, cycles;
    int unsigned rd_beat [2];
    int unsigned rd_done [2];
    logic rd_busy [2];
    logic wb_hs, r_hs, b_pending;
    logic ar_hs [2];

    mem_subsys_top i_mem_subsys_top (
        .aclk(aclk), .reset_i(reset_i),
        .fetch_ar_i(ar_req[0]), .fetch_ar_valid_i(ar_valid[0]),
        .fetch_ar_ready_o(fetch_ar_ready_o), .fetch_r_o(fetch_r_o),
        .fetch_r_valid_o(fetch_r_valid_o), .fetch_r_ready_i(r_ready[0]),
        .data_ar_i(ar_req[1]), .data_ar_valid_i(ar_valid[1]),
        .data_ar_ready_o(data_ar_ready_o), .data_r_o(data_r_o),
        .data_r_valid_o(data_r_valid_o), .data_r_ready_i(r_ready[1]),
        .wb_req_i(wb_req_i), .wb_req_valid_i(wb_req_valid_i),
        .wb_req_ready_o(wb_req_ready_o), .wb_empty_o(wb_empty_o),
        .lookup_paddr_i(lookup_paddr_i), .lookup_hit_o(lookup_hit_o),
        .lookup_line_o(lookup_line_o),
        .m_ar_o(m_ar_o), .m_ar_valid_o(m_ar_valid_o), .m_ar_ready_i(m_ar_ready_i),
        .m_r_i(m_r_i), .m_r_valid_i(m_r_valid_i), .m_r_ready_o(m_r_ready_o),
        .m_aw_o(m_aw_o), .m_aw_valid_o(m_aw_valid_o), .m_aw_ready_i(m_aw_ready_i),
        .m_w_o(m_w_o), .m_w_valid_o(m_w_valid_o), .m_w_ready_i(m_w_ready_i),
        .m_b_valid_i(m_b_valid_i), .m_b_ready_o(m_b_ready_o)
    );

    always #2 aclk = ~aclk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_q;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_q = x;
        return x;
    endfunction

    // read memory content, fixed for the lower half of the address space
    function automatic mem_pkg::word_t init_word(input mem_pkg::paddr_t a);
        return a ^ INIT_XOR;
    endfunction

    // slave memory, written words first and the init rule everywhere else
    function automatic mem_pkg::word_t slave_word(input mem_pkg::paddr_t a);
        if (wr_mem.exists(a)) begin
            return wr_mem[a];
        end
        return init_word(a);
    endfunction

    task automatic stop_failed();
        $display("=== FAIL ===");
        $fatal(1, "test stopped at the first error");
    endtask

    task automatic check_aw(input string name, input axi_pkg::axi_aw_t got, exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_failed();
        end
    endtask

    task automatic check_w(input string name, input axi_pkg::axi_w_t got, exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_failed();
        end
    endtask

    task automatic check_beat(input string name, input mem_pkg::rd_beat_t got, exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_failed();
        end
    endtask

    task automatic check_line(input string name, input mem_pkg::line_t got, exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
            stop_failed();
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, got);
            stop_failed();
        end
    endtask

    function automatic mem_pkg::wbuf_entry_t make_entry();
        mem_pkg::wbuf_entry_t e;
        logic [31:0] r;
        r = next_rand();
        e.uncached = (r[1:0] == 2'b00);
        for (int i = 0; i < mem_pkg::WORDS_PER_LINE; i++) begin
            e.line[i] = next_rand();
        end
        if (e.uncached) begin
            e.paddr = 32'h8000_0000 | (r & 32'h0000_03FC);
            e.strb  = (r[7:4] == 4'h0) ? 4'hF : r[7:4];
        end else begin
            e.paddr = 32'h8000_0000 | ((r & 32'h0000_0F00) >> 3);  // 16 lines, line aligned
            e.strb  = '0;
        end
        return e;
    endfunction

    task automatic drive_inputs();
        logic [31:0] r;
        if (!wb_req_valid_i || wb_hs) begin
            wb_req_valid_i = 1'b0;
            if (writes_sent < N_WRITES && next_rand() % 3 == 0) begin
                wb_req_i       = make_entry();
                wb_req_valid_i = 1'b1;
                writes_sent++;
            end
        end
        r = next_rand();
        if (wq.size() > 0 && r[0]) begin
            lookup_paddr_i = wq[r[9:8] % wq.size()].paddr | (r & 32'h1C);
        end else begin
            lookup_paddr_i = 32'h8000_0000 | ((r & 32'h0000_0F00) >> 3) | (r & 32'h1C);
        end
        for (int m = 0; m < 2; m++) begin
            if (ar_hs[m]) begin
                ar_valid[m] = 1'b0;
            end
            if (!rd_busy[m] && reads_issued < N_READS && next_rand() % 2 == 0) begin
                ar_req[m].addr = next_rand() & 32'h0FFF_FFFC;
                ar_req[m].len  = 4'(next_rand() % 8);
                ar_valid[m]    = 1'b1;
                rd_busy[m]     = 1'b1;
                rd_beat[m]     = 0;
                reads_issued++;
            end
            r_ready[m] = (next_rand() % 4 != 0);
        end
        m_ar_ready_i = (next_rand() % 4 != 0);
        m_aw_ready_i = (next_rand() % 4 != 0);
        m_w_ready_i  = (next_rand() % 4 != 0);
        if (!m_r_valid_i || r_hs) begin
            m_r_valid_i = 1'b0;
            if (slv_q.size() > 0 && next_rand() % 4 != 0) begin
                m_r_i.id    = slv_q[0].id;
                m_r_i.data  = slave_word(slv_q[0].addr + 32'(slv_beat * 4));
                m_r_i.last  = (slv_beat == 32'(slv_q[0].len));
                m_r_valid_i = 1'b1;
            end
        end
        // B is offered only for a finished burst and drops after its handshake
        if (!b_pending) begin
            m_b_valid_i = 1'b0;
        end else if (!m_b_valid_i && next_rand() % 2 == 0) begin
            m_b_valid_i = 1'b1;
        end
    endtask

    task automatic check_read_beat(input int m, input mem_pkg::rd_beat_t got);
        mem_pkg::rd_beat_t exp;
        exp.data = init_word(ar_req[m].addr + 32'(rd_beat[m] * 4));
        exp.last = (rd_beat[m] == 32'(ar_req[m].len));
        check_beat(m == 0 ? "fetch_r_o" : "data_r_o", got, exp);
        if (exp.last) begin
            rd_busy[m] = 1'b0;
            rd_done[m]++;
        end
        rd_beat[m]++;
    endtask

    task automatic sample_and_check();
        logic              exp_hit;
        mem_pkg::line_t    exp_line;
        axi_pkg::axi_aw_t  exp_aw;
        axi_pkg::axi_w_t   exp_w;
        logic              rsel;
        check_flag("wb_empty_o", wb_empty_o, wq.size() == 0);
        check_flag("wb_req_ready_o", wb_req_ready_o, wq.size() < mem_pkg::WBUF_DEPTH);
        check_flag("m_b_ready_o", m_b_ready_o, b_pending);
        exp_hit  = 1'b0;
        exp_line = '0;
        foreach (wq[i]) begin
            if (!wq[i].uncached && wq[i].paddr[31:5] == lookup_paddr_i[31:5]) begin
                exp_hit  = 1'b1;  // later entries are younger
                exp_line = wq[i].line;
            end
        end
        check_flag("lookup_hit_o", lookup_hit_o, exp_hit);
        if (exp_hit) begin
            check_line("lookup_line_o", lookup_line_o, exp_line);
        end
        if ((m_aw_valid_o || m_w_valid_o) && wq.size() == 0) begin
            $display("write burst started at %0t with no pending entry", $time);
            stop_failed();
        end
        if (m_aw_valid_o) begin
            exp_aw.addr = wq[0].paddr;
            exp_aw.len  = wq[0].uncached ? 4'd0 : 4'd7;
            check_aw("m_aw_o", m_aw_o, exp_aw);
        end
        if (m_w_valid_o) begin
            exp_w.data = wq[0].line[w_beat];
            exp_w.strb = wq[0].uncached ? wq[0].strb : 4'hF;
            exp_w.last = wq[0].uncached || w_beat == 7;
            check_w("m_w_o", m_w_o, exp_w);
        end
        rsel = (m_r_i.id == mem_pkg::MASTER_FETCH);
        check_flag("fetch_r_valid_o", fetch_r_valid_o, m_r_valid_i && rsel);
        check_flag("data_r_valid_o", data_r_valid_o, m_r_valid_i && !rsel);
        check_flag("m_r_ready_o", m_r_ready_o, rsel ? r_ready[0] : r_ready[1]);
        ar_hs[0] = ar_valid[0] && fetch_ar_ready_o;
        ar_hs[1] = ar_valid[1] && data_ar_ready_o;
        for (int m = 0; m < 2; m++) begin
            if (ar_hs[m]) begin
                check_flag("m_ar grant", m_ar_valid_o && m_ar_ready_i &&
                           m_ar_o.id == 4'(m) && m_ar_o.addr == ar_req[m].addr &&
                           m_ar_o.len == ar_req[m].len, 1'b1);
            end
        end
        if (fetch_r_valid_o && r_ready[0]) check_read_beat(0, fetch_r_o);
        if (data_r_valid_o && r_ready[1]) check_read_beat(1, data_r_o);
        // model updates for the handshakes at the coming edge
        if (m_ar_valid_o && m_ar_ready_i) slv_q.push_back(m_ar_o);
        r_hs = m_r_valid_i && m_r_ready_o;
        if (r_hs) begin
            slv_beat++;
            if (m_r_i.last) begin
                void'(slv_q.pop_front());
                slv_beat = 0;
            end
        end
        if (m_w_valid_o && m_w_ready_i) begin
            wr_mem[wq[0].paddr + 32'(w_beat * 4)] = m_w_o.data;
            w_beat    = m_w_o.last ? 0 : w_beat + 1;
            b_pending = m_w_o.last;
        end
        if (m_b_valid_i && m_b_ready_o) begin
            void'(wq.pop_front());
            b_pending = 1'b0;
            writes_done++;
        end
        wb_hs = wb_req_valid_i && wb_req_ready_o;
        if (wb_hs) wq.push_back(wb_req_i);
    endtask

    initial begin
        rng_q = 32'd46133;
        aclk = 1'b0;
        reset_i = 1'b1;
        wb_req_i = '0;
        wb_req_valid_i = 1'b0;
        lookup_paddr_i = '0;
        m_ar_ready_i = 1'b0;
        m_r_i = '0;
        m_r_valid_i = 1'b0;
        m_aw_ready_i = 1'b0;
        m_w_ready_i = 1'b0;
        m_b_valid_i = 1'b0;
        for (int m = 0; m < 2; m++) begin
            ar_req[m] = '0;
            ar_valid[m] = 1'b0;
            r_ready[m] = 1'b0;
            rd_busy[m] = 1'b0;
            rd_beat[m] = 0;
            rd_done[m] = 0;
            ar_hs[m] = 1'b0;
        end
        {slv_beat, w_beat, writes_sent, writes_done, reads_issued, cycles} = '0;
        {wb_hs, r_hs, b_pending} = '0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        reset_i = 1'b0;
        #1;
        check_flag("wb_empty_o", wb_empty_o, 1'b1);
        check_flag("m_ar_valid_o", m_ar_valid_o, 1'b0);
        check_flag("m_aw_valid_o", m_aw_valid_o, 1'b0);
        check_flag("m_w_valid_o", m_w_valid_o, 1'b0);
        check_flag("m_b_ready_o", m_b_ready_o, 1'b0);
        check_flag("fetch_r_valid_o", fetch_r_valid_o, 1'b0);
        check_flag("data_r_valid_o", data_r_valid_o, 1'b0);
        while (writes_done < N_WRITES || rd_done[0] + rd_done[1] < N_READS) begin
            @(negedge aclk);
            drive_inputs();
            #1;
            sample_and_check();
            cycles++;
            if (cycles > LIMIT) begin
                $display("timeout after %0d cycles, traffic did not complete", cycles);
                stop_failed();
            end
        end
        if (rd_done[0] > 0 && rd_done[1] > 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("a read master was never served");
            stop_failed();
        end
    end

endmodule

//--- test/wbuffer_drain_chk.sv
module wbuffer_drain_chk (
    input  logic             aclk,
    input  logic             reset_i,
    input  axi_pkg::axi_aw_t m_aw_o,
    input  logic             m_aw_valid_o,
    input  logic             m_aw_ready_i,
    input  axi_pkg::axi_w_t  m_w_o,
    input  logic             m_w_valid_o,
    input  logic             m_w_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic                          aw_done_q;  // AW accepted, burst data pending
    logic [axi_pkg::AXI_LEN_W-1:0] len_q;
    logic [axi_pkg::AXI_LEN_W-1:0] beat_q;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            aw_done_q <= 1'b0;
            len_q     <= '0;
            beat_q    <= '0;
        end else if (m_aw_valid_o && m_aw_ready_i) begin
            aw_done_q <= 1'b1;
            len_q     <= m_aw_o.len;
            beat_q    <= '0;
        end else if (m_w_valid_o && m_w_ready_i) begin
            aw_done_q <= !m_w_o.last;
            beat_q    <= m_w_o.last ? '0 : beat_q + 1'b1;
        end
    end

    aw_hold: assert property (@(posedge aclk) disable iff (reset_i)
        m_aw_valid_o && !m_aw_ready_i |=> m_aw_valid_o && $stable(m_aw_o))
        else $error("AW valid or payload changed before ready");
    w_hold: assert property (@(posedge aclk) disable iff (reset_i)
        m_w_valid_o && !m_w_ready_i |=> m_w_valid_o && $stable(m_w_o))
        else $error("W valid or payload changed before ready");
    w_last: assert property (@(posedge aclk) disable iff (reset_i)
        m_w_valid_o |-> (m_w_o.last == (beat_q == len_q)))
        else $error("wlast not on the beat numbered len");
    w_after_aw: assert property (@(posedge aclk) disable iff (reset_i)
        m_w_valid_o |-> aw_done_q)
        else $error("W beat before the AW handshake");

endmodule

bind wbuffer_drain wbuffer_drain_chk i_wbuffer_drain_chk (
    .aclk         (aclk),
    .reset_i      (reset_i),
    .m_aw_o       (m_aw_o),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_w_o        (m_w_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready_i)
);

//--- hdl/mem_subsys_top.sv
module mem_subsys_top (
    input  logic                 aclk,
    input  logic                 reset_i,
    // fetch read master
    input  mem_pkg::rd_req_t     fetch_ar_i,
    input  logic                 fetch_ar_valid_i,
    output logic                 fetch_ar_ready_o,
    output mem_pkg::rd_beat_t    fetch_r_o,
    output logic                 fetch_r_valid_o,
    input  logic                 fetch_r_ready_i,
    // data read master
    input  mem_pkg::rd_req_t     data_ar_i,
    input  logic                 data_ar_valid_i,
    output logic                 data_ar_ready_o,
    output mem_pkg::rd_beat_t    data_r_o,
    output logic                 data_r_valid_o,
    input  logic                 data_r_ready_i,
    // write buffer input and lookup
    input  mem_pkg::wbuf_entry_t wb_req_i,
    input  logic                 wb_req_valid_i,
    output logic                 wb_req_ready_o,
    output logic                 wb_empty_o,
    input  mem_pkg::paddr_t      lookup_paddr_i,
    output logic                 lookup_hit_o,
    output mem_pkg::line_t       lookup_line_o,
    // AXI read
    output axi_pkg::axi_ar_t     m_ar_o,
    output logic                 m_ar_valid_o,
    input  logic                 m_ar_ready_i,
    input  axi_pkg::axi_r_t      m_r_i,
    input  logic                 m_r_valid_i,
    output logic                 m_r_ready_o,
    // AXI write
    output axi_pkg::axi_aw_t     m_aw_o,
    output logic                 m_aw_valid_o,
    input  logic                 m_aw_ready_i,
    output axi_pkg::axi_w_t      m_w_o,
    output logic                 m_w_valid_o,
    input  logic                 m_w_ready_i,
    input  logic                 m_b_valid_i,
    output logic                 m_b_ready_o
);

    mem_pkg::wbuf_entry_t head;
    logic                 head_valid;
    logic                 pop;

    read_arbiter i_read_arbiter (
        .aclk             (aclk),
        .reset_i          (reset_i),
        .fetch_ar_i       (fetch_ar_i),
        .fetch_ar_valid_i (fetch_ar_valid_i),
        .fetch_ar_ready_o (fetch_ar_ready_o),
        .fetch_r_o        (fetch_r_o),
        .fetch_r_valid_o  (fetch_r_valid_o),
        .fetch_r_ready_i  (fetch_r_ready_i),
        .data_ar_i        (data_ar_i),
        .data_ar_valid_i  (data_ar_valid_i),
        .data_ar_ready_o  (data_ar_ready_o),
        .data_r_o         (data_r_o),
        .data_r_valid_o   (data_r_valid_o),
        .data_r_ready_i   (data_r_ready_i),
        .m_ar_o           (m_ar_o),
        .m_ar_valid_o     (m_ar_valid_o),
        .m_ar_ready_i     (m_ar_ready_i),
        .m_r_i            (m_r_i),
        .m_r_valid_i      (m_r_valid_i),
        .m_r_ready_o      (m_r_ready_o)
    );

    wbuffer_store i_wbuffer_store (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .wb_req_i       (wb_req_i),
        .wb_req_valid_i (wb_req_valid_i),
        .wb_req_ready_o (wb_req_ready_o),
        .wb_empty_o     (wb_empty_o),
        .lookup_paddr_i (lookup_paddr_i),
        .lookup_hit_o   (lookup_hit_o),
        .lookup_line_o  (lookup_line_o),
        .head_o         (head),
        .head_valid_o   (head_valid),
        .pop_i          (pop)
    );

    wbuffer_drain i_wbuffer_drain (
        .aclk         (aclk),
        .reset_i      (reset_i),
        .head_i       (head),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .m_aw_o       (m_aw_o),
        .m_aw_valid_o (m_aw_valid_o),
        .m_aw_ready_i (m_aw_ready_i),
        .m_w_o        (m_w_o),
        .m_w_valid_o  (m_w_valid_o),
        .m_w_ready_i  (m_w_ready_i),
        .m_b_valid_i  (m_b_valid_i),
        .m_b_ready_o  (m_b_ready_o)
    );

endmodule

//--- wbuffer/wbuffer_drain.sv
module wbuffer_drain (
    input  logic                 aclk,
    input  logic                 reset_i,
    // head of the entry queue
    input  mem_pkg::wbuf_entry_t head_i,
    input  logic                 head_valid_i,
    output logic                 pop_o,
    // AXI write channels
    output axi_pkg::axi_aw_t     m_aw_o,
    output logic                 m_aw_valid_o,
    input  logic                 m_aw_ready_i,
    output axi_pkg::axi_w_t      m_w_o,
    output logic                 m_w_valid_o,
    input  logic                 m_w_ready_i,
    input  logic                 m_b_valid_i,
    output logic                 m_b_ready_o
);

    typedef logic [axi_pkg::AXI_LEN_W-1:0] len_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } state_t;

    state_t state_q;
    logic [mem_pkg::WORD_IDX_W-1:0] beat_q;
    len_t burst_len;
    logic last_beat;

    // head stays put until the pop, so the payload is taken straight from it
    assign burst_len = head_i.uncached ? len_t'(0) : len_t'(mem_pkg::WORDS_PER_LINE - 1);
    assign last_beat = (len_t'(beat_q) == burst_len);

    assign m_aw_o.addr = head_i.paddr;
    assign m_aw_o.len  = burst_len;

    assign m_w_o.data = head_i.line[beat_q];
    assign m_w_o.strb = head_i.uncached ? head_i.strb : '1;
    assign m_w_o.last = last_beat;

    assign m_aw_valid_o = (state_q == ST_ADDR);
    assign m_w_valid_o  = (state_q == ST_DATA);
    assign m_b_ready_o  = (state_q == ST_RESP);
    assign pop_o        = m_b_ready_o && m_b_valid_i;  // entry retires on the B handshake

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (head_valid_i) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    beat_q <= '0;
                    if (m_aw_ready_i) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (m_w_ready_i) begin
                        if (last_beat) begin
                            state_q <= ST_RESP;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                ST_RESP: begin
                    if (m_b_valid_i) begin
                        state_q <= ST_IDLE;  // next head is seen a cycle later
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- wbuffer/wbuffer_store.sv
module wbuffer_store (
    input  logic                 aclk,
    input  logic                 reset_i,
    // from the data cache
    input  mem_pkg::wbuf_entry_t wb_req_i,
    input  logic                 wb_req_valid_i,
    output logic                 wb_req_ready_o,
    output logic                 wb_empty_o,
    // line lookup from the data cache
    input  mem_pkg::paddr_t      lookup_paddr_i,
    output logic                 lookup_hit_o,
    output mem_pkg::line_t       lookup_line_o,
    // to the drain
    output mem_pkg::wbuf_entry_t head_o,
    output logic                 head_valid_o,
    input  logic                 pop_i
);

    typedef logic [mem_pkg::WBUF_PTR_W-1:0] ptr_t;
    typedef logic [mem_pkg::WBUF_PTR_W:0]   cnt_t;

    localparam int TAG_LO = mem_pkg::LINE_OFF_W;
    localparam int TAG_HI = mem_pkg::PADDR_W - 1;

    mem_pkg::wbuf_entry_t entries_q [mem_pkg::WBUF_DEPTH];

    ptr_t wr_ptr_q;
    ptr_t rd_ptr_q;
    cnt_t count_q;
    logic push;

    assign wb_req_ready_o = (count_q != cnt_t'(mem_pkg::WBUF_DEPTH));
    assign wb_empty_o     = (count_q == '0);
    assign head_valid_o   = !wb_empty_o;
    assign head_o         = entries_q[rd_ptr_q];
    assign push           = wb_req_valid_i && wb_req_ready_o;

    always_ff @(posedge aclk) begin
        if (push) begin
            entries_q[wr_ptr_q] <= wb_req_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + ptr_t'(1);  // depth is a power of two, wraps
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
            case ({push, pop_i})
                2'b10:   count_q <= count_q + cnt_t'(1);
                2'b01:   count_q <= count_q - cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // walk from oldest to youngest so the youngest match is the one that stays
    always_comb begin
        ptr_t idx;
        lookup_hit_o  = 1'b0;
        lookup_line_o = '0;
        for (int k = 0; k < mem_pkg::WBUF_DEPTH; k++) begin
            idx = rd_ptr_q + ptr_t'(k);
            if ((cnt_t'(k) < count_q) && !entries_q[idx].uncached &&
                (entries_q[idx].paddr[TAG_HI:TAG_LO] == lookup_paddr_i[TAG_HI:TAG_LO])) begin
                lookup_hit_o  = 1'b1;
                lookup_line_o = entries_q[idx].line;
            end
        end
    end

endmodule

//--- hdl/read_arbiter.sv
module read_arbiter (
    input  logic              aclk,
    input  logic              reset_i,
    // instruction fetch master
    input  mem_pkg::rd_req_t  fetch_ar_i,
    input  logic              fetch_ar_valid_i,
    output logic              fetch_ar_ready_o,
    output mem_pkg::rd_beat_t fetch_r_o,
    output logic              fetch_r_valid_o,
    input  logic              fetch_r_ready_i,
    // data read master
    input  mem_pkg::rd_req_t  data_ar_i,
    input  logic              data_ar_valid_i,
    output logic              data_ar_ready_o,
    output mem_pkg::rd_beat_t data_r_o,
    output logic              data_r_valid_o,
    input  logic              data_r_ready_i,
    // shared AXI read channels
    output axi_pkg::axi_ar_t  m_ar_o,
    output logic              m_ar_valid_o,
    input  logic              m_ar_ready_i,
    input  axi_pkg::axi_r_t   m_r_i,
    input  logic              m_r_valid_i,
    output logic              m_r_ready_o
);

    logic locked_q;       // a granted request is waiting for arready
    logic locked_data_q;  // which master holds the locked grant
    logic last_data_q;    // data master was served last
    logic sel_data;
    logic r_to_fetch;
    mem_pkg::rd_req_t sel_req;

    always_comb begin
        if (locked_q) begin
            sel_data = locked_data_q;
        end else if (fetch_ar_valid_i && data_ar_valid_i) begin
            sel_data = ~last_data_q;  // round robin on contention
        end else begin
            sel_data = data_ar_valid_i;
        end
    end

    assign sel_req      = sel_data ? data_ar_i : fetch_ar_i;
    assign m_ar_valid_o = sel_data ? data_ar_valid_i : fetch_ar_valid_i;

    always_comb begin
        m_ar_o.id   = sel_data ? mem_pkg::MASTER_DATA : mem_pkg::MASTER_FETCH;
        m_ar_o.addr = sel_req.addr;
        m_ar_o.len  = sel_req.len;
    end

    assign fetch_ar_ready_o = m_ar_ready_i && !sel_data;
    assign data_ar_ready_o  = m_ar_ready_i && sel_data;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            locked_q      <= 1'b0;
            locked_data_q <= 1'b0;
            last_data_q   <= 1'b1;  // fetch wins the first tie
        end else if (m_ar_valid_o) begin
            if (m_ar_ready_i) begin
                locked_q    <= 1'b0;
                last_data_q <= sel_data;
            end else begin
                locked_q      <= 1'b1;  // hold grant until the handshake
                locked_data_q <= sel_data;
            end
        end
    end

    // R beats go back to the master named by rid
    assign r_to_fetch = (m_r_i.id == mem_pkg::MASTER_FETCH);

    assign fetch_r_o.data  = m_r_i.data;
    assign fetch_r_o.last  = m_r_i.last;
    assign data_r_o.data   = m_r_i.data;
    assign data_r_o.last   = m_r_i.last;
    assign fetch_r_valid_o = m_r_valid_i && r_to_fetch;
    assign data_r_valid_o  = m_r_valid_i && !r_to_fetch;
    assign m_r_ready_o     = r_to_fetch ? fetch_r_ready_i : data_r_ready_i;

endmodule

//--- common/mem_pkg.sv
package mem_pkg;

    localparam int WORD_W         = 32;
    localparam int PADDR_W        = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_IDX_W     = $clog2(WORDS_PER_LINE);
    localparam int LINE_OFF_W     = $clog2(WORDS_PER_LINE * WORD_W / 8);  // byte offset in a line

    localparam int WBUF_DEPTH = 4;
    localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);

    // read ids driven onto the AR channel, one per master
    localparam logic [axi_pkg::AXI_ID_W-1:0] MASTER_FETCH = 0;
    localparam logic [axi_pkg::AXI_ID_W-1:0] MASTER_DATA  = 1;

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    // uncached entry keeps its word in line[0] and its byte enables in strb
    typedef struct packed {
        paddr_t                paddr;
        line_t                 line;
        logic [WORD_W/8-1:0]   strb;
        logic                  uncached;
    } wbuf_entry_t;

    typedef struct packed {
        paddr_t                         addr;
        logic [axi_pkg::AXI_LEN_W-1:0]  len;
    } rd_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } rd_beat_t;

endpackage

//--- common/axi_pkg.sv
package axi_pkg;

    // bus-side widths of the single AXI3 master port
    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int AXI_LEN_W  = 4;  // AXI3 burst length field

    // size and burst type are fixed (one word, incr), so they are not carried

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_LEN_W-1:0]  len;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic                  last;
    } axi_r_t;

    // single writer, so the write channels carry no id
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_LEN_W-1:0]  len;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

endpackage
